// ==== project.f ====
logic/reducer_pkg.sv
logic/word_fifo.sv
logic/slice_sequencer.sv
logic/lane_select.sv
logic/width_reducer.sv
bench/reducer_props.sv
bench/tb_width_reducer.sv

// ==== Makefile ====
TOP = tb_width_reducer

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== bench/tb_width_reducer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_width_reducer;

  localparam int ADDR_WIDTH = 3;
  localparam int AF_MARGIN  = 2;
  localparam int DEPTH      = 1 << ADDR_WIDTH;

  logic                    CLK = 1'b0;
  logic                    RESETN;
  reducer_pkg::wide_word_u in_data;
  logic                    in_valid;
  logic                    in_ready;
  reducer_pkg::slice_t     out_slice;

  // reference model
  logic [31:0] exp_q[$];
  logic [31:0] exp_slice;
  logic [31:0] lfsr;
  int          occ;
  int          lane_seen;
  int          dropped;
  int          slices_seen;

  int error_count;
  int check_count;
  int tests_run;
  int tests_failed;

  // throughput tracking
  logic gap_check;
  logic stream_started;
  int   gap_count;

  width_reducer #(
    .FIFO_ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_AF_MARGIN  (AF_MARGIN)
  ) UUT (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_slice (out_slice)
  );

  bind slice_sequencer reducer_props u_props (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .status   (status),
    .pop      (pop),
    .lane_ctl (lane_ctl),
    .in_ready (in_ready)
  );

  always #4 CLK = ~CLK;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [127:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[126:0], lfsr[0]};
    end
  endtask

  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic drive_random_word();
    logic [127:0] w;
    take_bits(128, w);
    in_data.raw = w;
    in_valid    = 1'b1;
  endtask

  task automatic send_random_word();
    drive_random_word();
    step();
    in_valid = 1'b0;
  endtask

  task automatic check_idle_output(input string when);
    check_count++;
    assert (out_slice.valid === 1'b0 && out_slice.data === {32{1'b1}}) else begin
      $display("mismatch at %0t ns: out_slice %s is valid=%b data=%h, expected idle all ones",
               $time, when, out_slice.valid, out_slice.data);
      error_count++;
    end
  endtask

  task automatic wait_drain(input int limit, input string what);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      step();
      n++;
    end
    check_count++;
    assert (exp_q.size() == 0) else begin
      $display("%0t: %s: output did not drain within %0d cycles, %0d slices still missing",
               $time, what, limit, exp_q.size());
      error_count++;
    end
    // a few quiet cycles so a stray slice would show
    repeat (3) step();
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (error_count == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - err_before);
    end
  endtask

  // monitor and model, sampled on the edge before the DUT updates
  always @(posedge CLK) begin
    if (!RESETN) begin
      exp_q.delete();
      occ       = 0;
      lane_seen = 0;
    end else begin
      if (out_slice.valid) begin
        slices_seen++;
        check_count++;
        assert (exp_q.size() != 0) else begin
          $display("%0t: valid slice %h appeared with no word pending", $time, out_slice.data);
          error_count++;
        end
        if (exp_q.size() != 0) begin
          exp_slice = exp_q.pop_front();
          assert (out_slice.data === exp_slice) else begin
            $display("mismatch at %0t ns: slice got %h, expected %h",
                     $time, out_slice.data, exp_slice);
            error_count++;
          end
          lane_seen++;
          // fourth slice means the word left the fifo one edge ago
          if (lane_seen == 4) begin
            lane_seen = 0;
            occ--;
          end
        end
      end
      if (gap_check) begin
        if (out_slice.valid) begin
          stream_started = 1'b1;
        end else if (stream_started && exp_q.size() != 0) begin
          gap_count++;
        end
      end
      if (in_valid) begin
        if (occ < DEPTH) begin
          // lane 0 is the low slice
          for (int i = 0; i < 4; i++) begin
            exp_q.push_back(in_data.raw[i*32 +: 32]);
          end
          occ++;
        end else begin
          dropped++;
        end
      end
    end
  end

  initial begin
    int           err_before;
    int           n;
    int           sent;
    int           gap;
    int           dropped_before;
    int           slices_before;
    int           valid_count;
    logic         saw_ready_low;
    logic [127:0] r;

    RESETN         = 1'b0;
    in_valid       = 1'b0;
    in_data.raw    = '0;
    lfsr           = 32'd33;
    occ            = 0;
    lane_seen      = 0;
    dropped        = 0;
    slices_seen    = 0;
    error_count    = 0;
    check_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    gap_check      = 1'b0;
    stream_started = 1'b0;
    gap_count      = 0;

    // reset state
    err_before = error_count;
    repeat (3) begin
      step();
      check_idle_output("during reset");
    end
    RESETN = 1'b1;
    check_idle_output("right after reset");
    n = 0;
    while (!in_ready && n < 5) begin
      step();
      n++;
    end
    check_count++;
    assert (in_ready) else begin
      $display("%0t: in_ready did not rise within 5 cycles after reset", $time);
      error_count++;
    end
    valid_count = 0;
    repeat (6) begin
      if (out_slice.valid) begin
        valid_count++;
      end
      step();
    end
    check_count++;
    assert (valid_count == 0) else begin
      $display("%0t: %0d valid slices appeared after reset without a write",
               $time, valid_count);
      error_count++;
    end
    finish_test("reset_state", err_before);

    // single words with random gaps
    err_before = error_count;
    for (int k = 0; k < 12; k++) begin
      send_random_word();
      take_bits(3, r);
      gap = 4 + int'(r[2:0]);
      repeat (gap) step();
    end
    wait_drain(40, "slice_order");
    finish_test("slice_order", err_before);

    // one word every four cycles
    err_before     = error_count;
    slices_before  = slices_seen;
    gap_count      = 0;
    stream_started = 1'b0;
    gap_check      = 1'b1;
    for (int k = 0; k < 50; k++) begin
      send_random_word();
      repeat (3) step();
    end
    wait_drain(40, "throughput");
    gap_check = 1'b0;
    check_count++;
    assert (gap_count == 0) else begin
      $display("%0t: throughput: %0d idle cycles inside the slice stream", $time, gap_count);
      error_count++;
    end
    check_count++;
    assert (slices_seen - slices_before == 200) else begin
      $display("mismatch at %0t ns: throughput saw %0d slices, expected 200",
               $time, slices_seen - slices_before);
      error_count++;
    end
    finish_test("throughput", err_before);

    // full rate, source honors in_ready
    err_before     = error_count;
    dropped_before = dropped;
    saw_ready_low  = 1'b0;
    sent           = 0;
    n              = 0;
    while (sent < 40 && n < 400) begin
      if (in_ready) begin
        drive_random_word();
        sent++;
      end else begin
        in_valid      = 1'b0;
        saw_ready_low = 1'b1;
      end
      step();
      n++;
    end
    in_valid = 1'b0;
    check_count++;
    assert (sent == 40) else begin
      $display("%0t: ready_overflow: only %0d of 40 words sent before timeout", $time, sent);
      error_count++;
    end
    wait_drain(200, "ready_overflow");
    check_count++;
    assert (dropped == dropped_before) else begin
      $display("%0t: ready_overflow: %0d writes lost although in_ready was high",
               $time, dropped - dropped_before);
      error_count++;
    end
    check_count++;
    assert (saw_ready_low) else begin
      $display("%0t: ready_overflow: in_ready never fell during a full rate stream", $time);
      error_count++;
    end
    finish_test("ready_overflow", err_before);

    // every cycle, in_ready ignored
    err_before = error_count;
    for (int k = 0; k < 30; k++) begin
      drive_random_word();
      step();
    end
    in_valid = 1'b0;
    wait_drain(200, "burst");
    finish_test("burst", err_before);

    // reset while slices are flowing
    err_before = error_count;
    for (int k = 0; k < 6; k++) begin
      drive_random_word();
      step();
    end
    in_valid = 1'b0;
    repeat (5) step();
    RESETN = 1'b0;
    repeat (3) step();
    RESETN = 1'b1;
    check_idle_output("after mid-stream reset");
    valid_count = 0;
    repeat (10) begin
      if (out_slice.valid) begin
        valid_count++;
      end
      step();
    end
    check_count++;
    assert (valid_count == 0) else begin
      $display("%0t: reset_midstream: %0d valid slices after reset with no new write",
               $time, valid_count);
      error_count++;
    end
    send_random_word();
    wait_drain(20, "reset_midstream");
    finish_test("reset_midstream", err_before);

    error_count += UUT.u_slice_sequencer.u_props.fail_count;
    $display("tests run %0d, failed %0d, checks %0d, errors %0d, property failures %0d",
             tests_run, tests_failed, check_count, error_count,
             UUT.u_slice_sequencer.u_props.fail_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/reducer_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module reducer_props (
  input wire                            CLK,
  input wire                            RESETN,
  input wire reducer_pkg::fifo_status_t status,
  input wire                            pop,
  input wire reducer_pkg::lane_ctl_t    lane_ctl,
  input wire                            in_ready
);

  // failures seen, read by the testbench at the end
  int fail_count = 0;

  pop_needs_word: assert property (@(posedge CLK) disable iff (!RESETN)
    pop |-> status.not_empty)
    else begin
      $error("pop issued while the fifo is empty");
      fail_count++;
    end

  // the head only leaves with its last slice
  pop_on_last_lane: assert property (@(posedge CLK) disable iff (!RESETN)
    pop |-> (lane_ctl.lane == 2'd3))
    else begin
      $error("pop issued on lane %0d instead of lane 3", lane_ctl.lane);
      fail_count++;
    end

  lane_holds_when_empty: assert property (@(posedge CLK) disable iff (!RESETN)
    !status.not_empty |=> $stable(lane_ctl.lane))
    else begin
      $error("lane index moved while the fifo was empty");
      fail_count++;
    end

  ready_low_after_full: assert property (@(posedge CLK) disable iff (!RESETN)
    status.full |=> !in_ready)
    else begin
      $error("in_ready stayed high one cycle after full");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== logic/width_reducer.sv ====
`timescale 1ns/1ps
`default_nettype none

module width_reducer #(
  parameter int FIFO_ADDR_WIDTH = 3,
  parameter int FIFO_AF_MARGIN  = 2
) (
  input  wire                          CLK,
  input  wire                          RESETN,
  input  wire reducer_pkg::wide_word_u in_data,
  input  wire                          in_valid,
  output logic                         in_ready,
  output reducer_pkg::slice_t          out_slice
);

  // fifo head and flags
  reducer_pkg::wide_word_u   fifo_head;
  reducer_pkg::fifo_status_t fifo_status;

  // control from the sequencer
  logic                   fifo_pop;
  reducer_pkg::lane_ctl_t lane_ctl;

  // wide words land here straight from the source
  word_fifo #(
    .ADDR_WIDTH (FIFO_ADDR_WIDTH),
    .AF_MARGIN  (FIFO_AF_MARGIN)
  ) u_word_fifo (
    .CLK     (CLK),
    .RESETN  (RESETN),
    .wr_en   (in_valid),
    .wr_data (in_data),
    .pop     (fifo_pop),
    .head    (fifo_head),
    .status  (fifo_status)
  );

  slice_sequencer u_slice_sequencer (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .status   (fifo_status),
    .pop      (fifo_pop),
    .lane_ctl (lane_ctl),
    .in_ready (in_ready)
  );

  // one slice per clock, registered
  lane_select u_lane_select (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .head      (fifo_head),
    .lane_ctl  (lane_ctl),
    .out_slice (out_slice)
  );

endmodule

`default_nettype wire

// ==== logic/lane_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_select (
  input  wire                          CLK,
  input  wire                          RESETN,
  input  wire reducer_pkg::wide_word_u head,
  input  wire reducer_pkg::lane_ctl_t  lane_ctl,
  output reducer_pkg::slice_t          out_slice
);

  logic [reducer_pkg::SLICE_WIDTH-1:0] sel_data;
  reducer_pkg::slice_t                 slice_q;

  // pick the slice through the lanes view of the head word
  assign sel_data = head.lanes[lane_ctl.lane];

  // output register, data idles at all ones after reset
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      slice_q.valid <= 1'b0;
      slice_q.data  <= '1;
    end else begin
      slice_q.valid <= lane_ctl.active;
      slice_q.data  <= sel_data;
    end
  end

  assign out_slice = slice_q;

endmodule

`default_nettype wire

// ==== logic/slice_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module slice_sequencer (
  input  wire                           CLK,
  input  wire                           RESETN,
  input  wire reducer_pkg::fifo_status_t status,
  output logic                          pop,
  output reducer_pkg::lane_ctl_t        lane_ctl,
  output logic                          in_ready
);

  localparam logic [reducer_pkg::LANE_IDX_WIDTH-1:0] LAST_LANE =
    reducer_pkg::LANE_IDX_WIDTH'(reducer_pkg::LANES - 1);

  // current lane of the head word
  logic [reducer_pkg::LANE_IDX_WIDTH-1:0] lane_q;
  logic [reducer_pkg::LANE_IDX_WIDTH-1:0] lane_d;

  logic word_present;
  logic last_lane;
  logic ready_q;

  assign word_present = status.not_empty;
  assign last_lane    = (lane_q == LAST_LANE);

  // counter only moves while a word is waiting
  // so every word starts at lane 0
  always_comb begin
    lane_d = lane_q;
    if (word_present) begin
      if (last_lane) begin
        lane_d = '0;
      end else begin
        lane_d = lane_q + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      lane_q <= '0;
    end else begin
      lane_q <= lane_d;
    end
  end

  // head leaves the fifo together with its last slice
  assign pop = word_present && last_lane;

  always_comb begin
    lane_ctl.active = word_present;
    lane_ctl.lane   = lane_q;
  end

  // advisory ready, one cycle behind the fifo flags
  // low out of reset, the source should hold off until it rises
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= !(status.full || status.almost_full);
    end
  end

  assign in_ready = ready_q;

endmodule

`default_nettype wire

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
  parameter int ADDR_WIDTH = 3,
  parameter int AF_MARGIN  = 2
) (
  input  wire                        CLK,
  input  wire                        RESETN,
  input  wire                        wr_en,
  input  wire reducer_pkg::wide_word_u wr_data,
  input  wire                        pop,
  output reducer_pkg::wide_word_u    head,
  output reducer_pkg::fifo_status_t  status
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // occupancy levels in counter width
  localparam logic [ADDR_WIDTH:0] FULL_LEVEL = DEPTH[ADDR_WIDTH:0];
  localparam logic [ADDR_WIDTH:0] AF_LEVEL   = FULL_LEVEL - AF_MARGIN[ADDR_WIDTH:0];

  // storage holds the flat view of each word
  logic [reducer_pkg::WIDE_WIDTH-1:0] mem [DEPTH];

  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH:0]   count;

  logic is_empty;
  logic is_full;
  logic wr_ok;
  logic rd_ok;

  assign is_empty = (count == '0);
  assign is_full  = (count == FULL_LEVEL);

  // writes into a full fifo are lost, pops of an empty one ignored
  assign wr_ok = wr_en && !is_full;
  assign rd_ok = pop && !is_empty;

  always_ff @(posedge CLK) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data.raw;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy, simultaneous write and pop leave it unchanged
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // first word falls through to the head
  assign head.raw = mem[rd_ptr];

  always_comb begin
    status.not_empty   = !is_empty;
    status.full        = is_full;
    status.almost_full = (count >= AF_LEVEL);
  end

endmodule

`default_nettype wire

// ==== logic/reducer_pkg.sv ====
`default_nettype none

package reducer_pkg;

  // fixed word geometry, four slices per wide word
  localparam int WIDE_WIDTH     = 128;
  localparam int SLICE_WIDTH    = 32;
  localparam int LANES          = 4;
  localparam int LANE_IDX_WIDTH = 2;

  // one wide word, seen as flat bits or as its slices
  // lane 0 sits in the low bits
  typedef union packed {
    logic [WIDE_WIDTH-1:0]              raw;
    logic [LANES-1:0][SLICE_WIDTH-1:0] lanes;
  } wide_word_u;

  // fifo occupancy flags
  typedef struct packed {
    logic not_empty;
    logic full;
    logic almost_full;
  } fifo_status_t;

  // sequencer to lane selector
  typedef struct packed {
    logic                      active;
    logic [LANE_IDX_WIDTH-1:0] lane;
  } lane_ctl_t;

  // narrow output slice
  typedef struct packed {
    logic                   valid;
    logic [SLICE_WIDTH-1:0] data;
  } slice_t;

endpackage

`default_nettype wire
